//--- flist.f
mipsIsaPkg.sv
shiftUnitPkg.sv
shiftLaneIf.sv
shiftDecode.sv
shiftStage.sv
resultQueue.sv
shiftUnit.sv
shiftUnitTb.sv

//--- Makefile
# Verilator build for the shift unit and its testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = shiftUnitTb
RTL_TOP  = shiftUnit
FILELIST = flist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Testbench passed

.PHONY: all lint sim clean

all: sim

# Lint the design alone, then with the testbench
lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

# Build, run, and decide the result from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- shiftUnitTb.sv
//--------------------
// Shift unit testbench
// Random MIPS shift traffic with credit flow, checked against a model
//--------------------
`timescale 1ns/1ps

module shiftUnitTb;
    import mipsIsaPkg::*;
    import shiftUnitPkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int OUT_CREDITS = 2;
    localparam int INSTR_COUNT = 600;
    localparam int SEND_TIMEOUT = 20000;
    localparam int DRAIN_TIMEOUT = 2000;

    logic       clk;
    logic       reset;
    logic       inValid;
    instrT      instr;
    wordT       rsValue;
    wordT       rtValue;
    logic [1:0] inCredit;
    logic       outCredit;
    logic       outValid;
    wordT       outData;
    regIdxT     outDest;

    integer seed = 69037;
    // Credits the upstream side may still spend
    int inCredits;
    // Output credits the unit has registered and not yet used by a result
    int grantedCredits;
    // Credit pulse from the previous cycle, not yet in the unit's count
    logic creditPending;
    // Results taken whose credit is not yet returned
    int heldCredits;
    // Cycles left in a stretch of withheld output credits
    int holdLeft;
    // Expected results in acceptance order
    wordT   expData [$];
    regIdxT expDest [$];

    shiftUnit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_shiftUnit (
        .clk       (clk),
        .reset     (reset),
        .inValid   (inValid),
        .instr     (instr),
        .rsValue   (rsValue),
        .rtValue   (rtValue),
        .inCredit  (inCredit),
        .outCredit (outCredit),
        .outValid  (outValid),
        .outData   (outData),
        .outDest   (outDest)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //--------------------
    // Reference model
    // Left and logical right shifts insert zeros, arithmetic copies bit 31
    function automatic wordT expectedShift(
        input functT funct,
        input wordT  rt,
        input shamtT amount
    );
        case (funct)
            SLL_FUNC, SLLV_FUNC: return rt << amount;
            SRL_FUNC, SRLV_FUNC: return rt >> amount;
            default:             return wordT'($signed(rt) >>> amount);
        endcase
    endfunction

    function automatic logic isShiftWord(input instrT word);
        functT funct;
        funct = word[FUNCT_LSB +: $bits(functT)];
        if (word[OPCODE_LSB +: $bits(opcodeT)] != SPECIAL_OP) return 1'b0;
        return funct == SLL_FUNC || funct == SRL_FUNC || funct == SRA_FUNC ||
               funct == SLLV_FUNC || funct == SRLV_FUNC || funct == SRAV_FUNC;
    endfunction

    //--------------------
    // Checks
    task automatic reportFailure(input string why);
        $display("%s at time %0t", why, $time);
        $display("Testbench failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic checkData(input wordT actual, input wordT expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: outData %h, expected %h", $time, actual, expected);
            $display("Testbench failed");
            $fatal(1, "result data wrong");
        end
    endtask

    task automatic checkDest(input regIdxT actual, input regIdxT expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: outDest %0d, expected %0d", $time, actual, expected);
            $display("Testbench failed");
            $fatal(1, "result destination wrong");
        end
    endtask

    //--------------------
    // Stimulus
    // About 15% non-shift words and otherwise one of the six shifts
    task automatic driveInstruction();
        instrT word;
        functT funct;
        shamtT amount;
        int    pick;
        word = $random(seed);
        rsValue = $random(seed);
        rtValue = $random(seed);
        pick = $unsigned($random(seed)) % 100;
        if (pick < 15) begin
            // Any word that decodes as a shift becomes an ADDI
            if (isShiftWord(word)) word[OPCODE_LSB +: $bits(opcodeT)] = 6'h08;
        end else begin
            case (pick % 6)
                0:       funct = SLL_FUNC;
                1:       funct = SRL_FUNC;
                2:       funct = SRA_FUNC;
                3:       funct = SLLV_FUNC;
                4:       funct = SRLV_FUNC;
                default: funct = SRAV_FUNC;
            endcase
            word[OPCODE_LSB +: $bits(opcodeT)] = SPECIAL_OP;
            word[FUNCT_LSB +: $bits(functT)] = funct;
            // Edge amounts now and then
            pick = $unsigned($random(seed)) % 8;
            if (pick < 2) begin
                word[SHAMT_LSB +: $bits(shamtT)] = (pick == 0) ? 5'd0 : 5'd31;
                rsValue[4:0] = (pick == 0) ? 5'd0 : 5'd31;
            end
            if (funct == SLLV_FUNC || funct == SRLV_FUNC || funct == SRAV_FUNC)
                amount = rsValue[4:0];
            else
                amount = word[SHAMT_LSB +: $bits(shamtT)];
            expData.push_back(expectedShift(funct, rtValue, amount));
            expDest.push_back(word[RD_LSB +: $bits(regIdxT)]);
        end
        instr = word;
        inValid = 1'b1;
        inCredits = inCredits - 1;
    endtask

    // Random credit return with occasional long holds
    task automatic returnOutputCredit();
        if (holdLeft > 0) begin
            holdLeft = holdLeft - 1;
        end else if ($unsigned($random(seed)) % 50 == 0) begin
            holdLeft = 20 + int'($unsigned($random(seed)) % 40);
        end else if (heldCredits > 0 && $unsigned($random(seed)) % 3 != 0) begin
            outCredit = 1'b1;
            heldCredits = heldCredits - 1;
        end
    endtask

    //--------------------
    // Response monitor on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if ($isunknown({outValid, inCredit})) begin
                reportFailure("outValid or inCredit is unknown");
            end
            if (outValid) begin
                if (expData.size() == 0) reportFailure("result appeared with no shift pending");
                if (grantedCredits == 0) reportFailure("result sent without a downstream credit");
                checkData(outData, expData.pop_front());
                checkDest(outDest, expDest.pop_front());
                grantedCredits = grantedCredits - 1;
                heldCredits = heldCredits + 1;
            end
            // A returned credit reaches the unit's count one cycle after its pulse
            if (creditPending) grantedCredits = grantedCredits + 1;
            creditPending = outCredit;
            inCredits = inCredits + int'(inCredit);
            if (inCredits > QUEUE_DEPTH) reportFailure("more input credits returned than spent");
        end
    end

    //--------------------
    // Main sequence
    initial begin
        int cycles;
        int sent;
        reset = 1'b1;
        inValid = 1'b0;
        instr = '0;
        rsValue = '0;
        rtValue = '0;
        outCredit = 1'b0;
        inCredits = QUEUE_DEPTH;
        grantedCredits = OUT_CREDITS;
        creditPending = 1'b0;
        heldCredits = 0;
        holdLeft = 0;
        sent = 0;
        cycles = 0;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        while (sent < INSTR_COUNT) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
            outCredit = 1'b0;
            if (cycles >= SEND_TIMEOUT) reportFailure("timed out waiting for input credits");
            cycles = cycles + 1;
            if (inCredits > 0 && $unsigned($random(seed)) % 4 != 0) begin
                driveInstruction();
                sent = sent + 1;
            end
            returnOutputCredit();
        end

        // Return held credits one per cycle until everything drains
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
            outCredit = 1'b0;
            if (cycles >= DRAIN_TIMEOUT) reportFailure("timed out draining results");
            cycles = cycles + 1;
            if (heldCredits > 0) begin
                outCredit = 1'b1;
                heldCredits = heldCredits - 1;
            end
        end while (expData.size() != 0 || inCredits != QUEUE_DEPTH || heldCredits != 0);
        @(posedge clk);
        #1 outCredit = 1'b0;
        @(negedge clk);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- shiftUnit.sv
//--------------------
// Shift execution unit
// Decode, barrel stage chain and result queue with credit handshakes
//--------------------
`timescale 1ns/1ps

module shiftUnit #(
    parameter int QUEUE_DEPTH = shiftUnitPkg::DEFAULT_QUEUE_DEPTH,
    parameter int OUT_CREDITS = shiftUnitPkg::DEFAULT_OUT_CREDITS
) (
    input  logic                 clk,
    input  logic                 reset,
    // Instruction side
    input  logic                 inValid,
    input  mipsIsaPkg::instrT    instr,
    input  shiftUnitPkg::wordT   rsValue,
    input  shiftUnitPkg::wordT   rtValue,
    // Credits returned this cycle, 0..2
    output logic [1:0]           inCredit,
    // Result side
    input  logic                 outCredit,
    output logic                 outValid,
    output shiftUnitPkg::wordT   outData,
    output mipsIsaPkg::regIdxT   outDest
);
    import shiftUnitPkg::*;

    // Lane 0 from decode, lane STAGE_COUNT into the queue
    shiftLaneIf lanes [STAGE_COUNT+1] ();

    logic dropCredit;
    logic freeCredit;

    //--------------------
    // Decode
    shiftDecode uDecode (
        .clk        (clk),
        .reset      (reset),
        .inValid    (inValid),
        .instr      (instr),
        .rsValue    (rsValue),
        .rtValue    (rtValue),
        .dropCredit (dropCredit),
        .lane       (lanes[0])
    );

    //--------------------
    // Barrel chain
    // Stage i handles amount bit i
    for (genvar i = 0; i < STAGE_COUNT; i++) begin : gStage
        shiftStage #(
            .STAGE_INDEX (i)
        ) uStage (
            .clk      (clk),
            .reset    (reset),
            .upLane   (lanes[i]),
            .downLane (lanes[i+1])
        );
    end

    //--------------------
    // Result queue
    resultQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) uQueue (
        .clk        (clk),
        .reset      (reset),
        .lane       (lanes[STAGE_COUNT]),
        .outCredit  (outCredit),
        .outValid   (outValid),
        .outData    (outData),
        .outDest    (outDest),
        .freeCredit (freeCredit)
    );

    // A dropped word and a popped result may free slots in the same cycle
    assign inCredit = {1'b0, dropCredit} + {1'b0, freeCredit};

endmodule

//--- resultQueue.sv
//--------------------
// Result queue
// Restores left shifts, buffers results, releases them against credits
//--------------------
`timescale 1ns/1ps

module resultQueue #(
    parameter int QUEUE_DEPTH = shiftUnitPkg::DEFAULT_QUEUE_DEPTH,
    parameter int OUT_CREDITS = shiftUnitPkg::DEFAULT_OUT_CREDITS
) (
    input  logic                 clk,
    input  logic                 reset,
    shiftLaneIf.sink             lane,
    input  logic                 outCredit,
    output logic                 outValid,
    output shiftUnitPkg::wordT   outData,
    output mipsIsaPkg::regIdxT   outDest,
    output logic                 freeCredit
);
    import mipsIsaPkg::*;
    import shiftUnitPkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    typedef logic [PTR_W-1:0] ptrT;

    // Storage, circular over QUEUE_DEPTH slots
    wordT   memData [QUEUE_DEPTH];
    regIdxT memDest [QUEUE_DEPTH];

    ptrT    wrPtr;
    ptrT    rdPtr;
    creditT fillCount;
    // Credits the consumer has granted and not yet used
    creditT downCredits;
    logic   pop;
    wordT   laneWord;

    // Wrap explicitly, depth need not be a power of two
    function automatic ptrT nextPtr(input ptrT ptr);
        return (ptr == ptrT'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Mirror left shifts back to normal bit order
    assign laneWord = lane.reverse ? bitReverse(lane.data) : lane.data;

    // Release one entry when something is held and the consumer has room
    assign pop = (fillCount != '0) && (downCredits != '0);
    // Leaving the queue frees an input slot
    assign freeCredit = pop;

    //--------------------
    // FIFO storage
    always_ff @(posedge clk) begin
        if (lane.valid) begin
            memData[wrPtr] <= laneWord;
            memDest[wrPtr] <= lane.dest;
        end
    end

    //--------------------
    // Pointers, occupancy and downstream credits
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fillCount <= '0;
            downCredits <= creditT'(OUT_CREDITS);
        end else begin
            if (lane.valid) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            case ({lane.valid, pop})
                2'b10:   fillCount <= fillCount + 1'b1;
                2'b01:   fillCount <= fillCount - 1'b1;
                default: fillCount <= fillCount;
            endcase
            downCredits <= downCredits - creditT'(pop) + creditT'(outCredit);
        end
    end

    //--------------------
    // Output register
    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            outData <= memData[rdPtr];
            outDest <= memDest[rdPtr];
        end
    end

    // Input credits bound the words in flight, so a full queue is never written
    assert property (@(posedge clk) disable iff (reset)
        lane.valid |-> fillCount < creditT'(QUEUE_DEPTH))
        else $error("result queue written while full");

    // Consumer may only return credits it was given
    assert property (@(posedge clk) disable iff (reset)
        downCredits <= creditT'(OUT_CREDITS))
        else $error("downstream credit count above OUT_CREDITS");

endmodule

//--- shiftStage.sv
//--------------------
// Barrel shifter stage
// Shifts right by 2**STAGE_INDEX when that amount bit is set
//--------------------
`timescale 1ns/1ps

module shiftStage #(
    parameter int STAGE_INDEX = 0
) (
    input  logic        clk,
    input  logic        reset,
    shiftLaneIf.sink    upLane,
    shiftLaneIf.source  downLane
);
    import shiftUnitPkg::*;

    // Distance this stage moves the word
    localparam int SHIFT = 1 << STAGE_INDEX;

    wordT shifted;

    //--------------------
    // Conditional shift
    // Vacated top bits take the fill bit, zero or sign
    always_comb begin
        if (upLane.amount[STAGE_INDEX]) begin
            shifted = {{SHIFT{upLane.fill}}, upLane.data[DATA_WIDTH-1:SHIFT]};
        end else begin
            shifted = upLane.data;
        end
    end

    //--------------------
    // Pipeline register
    // No stall, a valid word always advances one stage per clock
    always_ff @(posedge clk) begin
        if (reset) begin
            downLane.valid <= 1'b0;
        end else begin
            downLane.valid <= upLane.valid;
        end
    end

    // Payload follows its valid bit
    always_ff @(posedge clk) begin
        downLane.data <= shifted;
        downLane.amount <= upLane.amount;
        downLane.fill <= upLane.fill;
        downLane.reverse <= upLane.reverse;
        downLane.dest <= upLane.dest;
    end

endmodule

//--- shiftDecode.sv
//--------------------
// Shift decode
// Recognises the six shifts and loads lane 0, returns credit for others
//--------------------
`timescale 1ns/1ps

module shiftDecode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inValid,
    input  mipsIsaPkg::instrT    instr,
    input  shiftUnitPkg::wordT   rsValue,
    input  shiftUnitPkg::wordT   rtValue,
    output logic                 dropCredit,
    shiftLaneIf.source           lane
);
    import mipsIsaPkg::*;
    import shiftUnitPkg::*;

    //--------------------
    // Field extraction
    opcodeT opcode;
    functT  funct;
    shamtT  shamtField;
    regIdxT rdField;

    assign opcode = instr[OPCODE_LSB +: $bits(opcodeT)];
    assign funct = instr[FUNCT_LSB +: $bits(functT)];
    assign shamtField = instr[SHAMT_LSB +: $bits(shamtT)];
    assign rdField = instr[RD_LSB +: $bits(regIdxT)];

    // Instruction class flags
    logic isShift;
    logic isVariable;
    logic isArith;
    logic isLeft;

    always_comb begin
        isShift = 1'b0;
        isVariable = 1'b0;
        isArith = 1'b0;
        isLeft = 1'b0;
        if (opcode == SPECIAL_OP) begin
            case (funct)
                SLL_FUNC:  {isShift, isLeft} = 2'b11;
                SRL_FUNC:  isShift = 1'b1;
                SRA_FUNC:  {isShift, isArith} = 2'b11;
                SLLV_FUNC: {isShift, isVariable, isLeft} = 3'b111;
                SRLV_FUNC: {isShift, isVariable} = 2'b11;
                SRAV_FUNC: {isShift, isVariable, isArith} = 3'b111;
                default:   isShift = 1'b0;
            endcase
        end
    end

    //--------------------
    // Operand setup
    shamtT amountSel;
    logic  fillSel;
    wordT  dataSel;

    // Variable forms take the low five bits of rs
    assign amountSel = isVariable ? rsValue[$bits(shamtT)-1:0] : shamtField;
    // Sign fill only for arithmetic right shifts
    assign fillSel = isArith & rtValue[DATA_WIDTH-1];
    // Left shifts run through the right-shift chain mirrored
    assign dataSel = isLeft ? bitReverse(rtValue) : rtValue;

    //--------------------
    // Lane 0 register
    always_ff @(posedge clk) begin
        if (reset) begin
            lane.valid <= 1'b0;
            dropCredit <= 1'b0;
        end else begin
            lane.valid <= inValid & isShift;
            // Non-shift word is consumed here, its credit goes straight back
            dropCredit <= inValid & ~isShift;
        end
    end

    // Payload only loads on an accepted shift
    always_ff @(posedge clk) begin
        if (inValid && isShift) begin
            lane.data <= dataSel;
            lane.amount <= amountSel;
            lane.fill <= fillSel;
            lane.reverse <= isLeft;
            lane.dest <= rdField;
        end
    end

    // Upstream must stay idle while the unit is held in reset
    assert property (@(posedge clk) reset |-> !inValid)
        else $error("inValid asserted during reset");

endmodule

//--- shiftLaneIf.sv
//--------------------
// Shift lane
// One in-flight shift between two pipeline registers
//--------------------
`timescale 1ns/1ps

interface shiftLaneIf;
    import mipsIsaPkg::*;
    import shiftUnitPkg::*;

    // Slot holds a live shift
    logic valid;
    // Word being shifted, mirrored for left shifts
    wordT data;
    // Remaining shift amount, one bit per stage
    shamtT amount;
    // Bit copied into vacated top positions
    logic fill;
    // Left shift, word must be mirrored back at the end
    logic reverse;
    // Destination register from rd
    regIdxT dest;

    //--------------------
    // Producer side, decode or a stage output
    modport source (
        output valid, data, amount, fill, reverse, dest
    );

    // Consumer side, a stage input or the queue
    modport sink (
        input valid, data, amount, fill, reverse, dest
    );

endinterface

//--- shiftUnitPkg.sv
//--------------------
// Shift unit definitions
// Datapath width, pipeline sizing, credit type and bit reversal
//--------------------
package shiftUnitPkg;

    //--------------------
    // Sizing

    // Width of one data word
    localparam int DATA_WIDTH = 32;
    // One barrel stage per amount bit
    localparam int STAGE_COUNT = $clog2(DATA_WIDTH);
    // Result slots, also the number of input credits
    // Must cover every word in flight, so 8..15
    localparam int DEFAULT_QUEUE_DEPTH = 8;
    // Credits the consumer grants after reset
    localparam int DEFAULT_OUT_CREDITS = 2;

    //--------------------
    // Types

    // Operand and result word
    typedef logic [DATA_WIDTH-1:0] wordT;
    // Credit or occupancy count, good up to 15
    typedef logic [3:0] creditT;

    // Mirror a word end for end
    // Turns a left shift into a right shift and back again
    function automatic wordT bitReverse(input wordT value);
        wordT result;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            result[i] = value[DATA_WIDTH-1-i];
        end
        return result;
    endfunction

endpackage

//--- mipsIsaPkg.sv
//--------------------
// MIPS I instruction set fields
// Field types, field positions and the R-type shift encodings
//--------------------
package mipsIsaPkg;

    //--------------------
    // Field types

    // Raw instruction word as fetched
    typedef logic [31:0] instrT;
    // Major opcode, top six bits
    typedef logic [5:0] opcodeT;
    // Function field, only meaningful under the special opcode
    typedef logic [5:0] functT;
    // General register index, used for rs, rt and rd
    typedef logic [4:0] regIdxT;
    // Fixed shift amount carried in the instruction
    typedef logic [4:0] shamtT;

    //--------------------
    // Field positions
    // Low bit of each field inside instrT, R-type layout
    // op(31:26) rs(25:21) rt(20:16) rd(15:11) shamt(10:6) funct(5:0)
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;

    //--------------------
    // Encodings

    // All shifts live under the special opcode
    localparam opcodeT SPECIAL_OP = 6'b000000;

    // Fixed-amount shifts, amount from shamt
    localparam functT SLL_FUNC = 6'b000000;
    localparam functT SRL_FUNC = 6'b000010;
    localparam functT SRA_FUNC = 6'b000011;
    // Variable shifts, amount from rs[4:0]
    localparam functT SLLV_FUNC = 6'b000100;
    localparam functT SRLV_FUNC = 6'b000110;
    localparam functT SRAV_FUNC = 6'b000111;

endpackage
